// ==== verilog/cache_pkg.sv ====
package cache_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // direct-mapped geometry, one word per block
  localparam int NUM_SETS = 16;
  localparam int OFFSET_W = 2;
  localparam int INDEX_W = $clog2(NUM_SETS);
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } req_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITEBACK,
    ST_FILL,
    ST_RESPOND
  } cache_state_e;

  typedef struct packed {
    req_op_e op;
    addr_t   addr;
    data_t   wdata;
    strb_t   wstrb;
  } proc_req_t;

  // rdata is zero for a write
  typedef struct packed {
    req_op_e op;
    data_t   rdata;
  } proc_resp_t;

  // memory writes are always full word
  typedef struct packed {
    req_op_e op;
    addr_t   addr;
    data_t   wdata;
  } mem_req_t;

endpackage

// ==== verilog/cache_tags.sv ====
`timescale 1ns/1ns

module cache_tags (
  input  logic             ACLK,
  input  logic             ARESETn,
  input  cache_pkg::addr_t lookup_addr,
  input  logic             tag_fill,
  input  logic             mark_dirty,
  output logic             hit,
  output logic             victim_dirty,
  output cache_pkg::addr_t victim_addr
);
  import cache_pkg::*;

  index_t set_idx;
  tag_t   req_tag;

  // per-set state
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;
  tag_t                tag_q [NUM_SETS];

  assign set_idx = lookup_addr[OFFSET_W +: INDEX_W];
  assign req_tag = lookup_addr[ADDR_W-1 -: TAG_W];

  assign hit = valid_q[set_idx] && (tag_q[set_idx] == req_tag);

  // an invalid line never needs a writeback
  assign victim_dirty = valid_q[set_idx] && dirty_q[set_idx];
  assign victim_addr  = {tag_q[set_idx], set_idx, {OFFSET_W{1'b0}}};

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (tag_fill) begin
        valid_q[set_idx] <= 1'b1;
        // a fill for a write miss lands dirty right away
        dirty_q[set_idx] <= mark_dirty;
      end else if (mark_dirty) begin
        dirty_q[set_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (tag_fill) begin
      tag_q[set_idx] <= req_tag;
    end
  end

endmodule

// ==== verilog/cache_data.sv ====
`timescale 1ns/1ns

module cache_data (
  input  logic              ACLK,
  input  cache_pkg::index_t index,
  input  logic              fill,
  input  logic              write,
  input  cache_pkg::data_t  fill_data,
  input  cache_pkg::data_t  wdata,
  input  cache_pkg::strb_t  wstrb,
  output cache_pkg::data_t  rd_data
);
  import cache_pkg::*;

  data_t words_q [NUM_SETS];
  data_t base_word;
  data_t merged_word;

  // fill and strobed write can land in the same cycle (write-allocate)
  always_comb begin
    base_word   = fill ? fill_data : words_q[index];
    merged_word = base_word;
    if (write) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wstrb[i]) begin
          merged_word[8*i +: 8] = wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (fill || write) begin
      words_q[index] <= merged_word;
    end
  end

  assign rd_data = words_q[index];

endmodule

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ns

module mem_port (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  cache_pkg::mem_req_t cmd,
  input  logic                cmd_valid,
  output cache_pkg::mem_req_t mem_req,
  output logic                mem_req_valid,
  input  logic                mem_req_ready,
  input  logic                mem_resp_valid,
  input  cache_pkg::data_t    mem_resp_rdata,
  output logic                mem_resp_ready,
  output logic                done,
  output cache_pkg::data_t    done_rdata
);
  import cache_pkg::*;

  mem_req_t req_q;
  logic     req_valid_q;
  logic     wait_resp_q;
  logic     done_q;
  data_t    rdata_q;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      req_valid_q <= 1'b0;
      wait_resp_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (cmd_valid) begin
        req_valid_q <= 1'b1;
      end else if (req_valid_q && mem_req_ready) begin
        req_valid_q <= 1'b0;
        wait_resp_q <= 1'b1;
      end
      if (wait_resp_q && mem_resp_valid) begin
        wait_resp_q <= 1'b0;
        done_q      <= 1'b1;
      end
    end
  end

  // payload only
  always_ff @(posedge ACLK) begin
    if (cmd_valid) begin
      req_q <= cmd;
    end
    if (wait_resp_q && mem_resp_valid) begin
      rdata_q <= mem_resp_rdata;
    end
  end

  assign mem_req        = req_q;
  assign mem_req_valid  = req_valid_q;
  assign mem_resp_ready = wait_resp_q;
  assign done           = done_q;
  assign done_rdata     = rdata_q;

  a_req_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else $error("mem_req changed while waiting for ready");

  a_one_outstanding: assert property (@(posedge ACLK) disable iff (!ARESETn)
    cmd_valid |-> !(mem_req_valid || mem_resp_ready))
    else $error("memory command issued while another is outstanding");

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl (
  input  logic                  ACLK,
  input  logic                  ARESETn,
  input  cache_pkg::proc_req_t  proc_req,
  input  logic                  proc_req_valid,
  output logic                  proc_req_ready,
  output cache_pkg::proc_resp_t proc_resp,
  output logic                  proc_resp_valid,
  input  logic                  proc_resp_ready,
  output cache_pkg::addr_t      lookup_addr,
  input  logic                  hit,
  input  logic                  victim_dirty,
  input  cache_pkg::addr_t      victim_addr,
  output logic                  tag_fill,
  output logic                  mark_dirty,
  output logic                  data_fill,
  output logic                  data_write,
  output cache_pkg::data_t      wdata,
  output cache_pkg::strb_t      wstrb,
  input  cache_pkg::data_t      rd_data,
  output cache_pkg::mem_req_t   mem_cmd,
  output logic                  mem_cmd_valid,
  input  logic                  mem_done,
  input  cache_pkg::data_t      mem_rdata
);
  import cache_pkg::*;

  cache_state_e state_q;
  cache_state_e next_state;
  proc_req_t    saved_q;
  proc_req_t    cur;
  proc_resp_t   resp_q;
  proc_resp_t   resp_next;
  logic         resp_valid_q;
  logic         resp_free;
  logic         resp_load;
  logic         accept;

  // the slot is free if empty or draining this cycle
  assign resp_free      = !resp_valid_q || proc_resp_ready;
  assign proc_req_ready = (state_q == ST_IDLE) && resp_free;
  assign accept         = proc_req_valid && proc_req_ready;

  // incoming request while idle, saved one during a miss
  assign cur         = (state_q == ST_IDLE) ? proc_req : saved_q;
  assign lookup_addr = cur.addr;
  assign wdata       = cur.wdata;
  assign wstrb       = cur.wstrb;

  always_comb begin
    next_state    = state_q;
    tag_fill      = 1'b0;
    mark_dirty    = 1'b0;
    data_fill     = 1'b0;
    data_write    = 1'b0;
    mem_cmd_valid = 1'b0;
    mem_cmd       = '{op: OP_READ, addr: {cur.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}},
                      wdata: '0};
    resp_load     = 1'b0;
    resp_next     = '{op: cur.op, rdata: '0};
    case (state_q)
      ST_IDLE: begin
        if (accept && hit) begin
          resp_load = 1'b1;
          if (cur.op == OP_WRITE) begin
            data_write = 1'b1;
            mark_dirty = 1'b1;
          end else begin
            resp_next.rdata = rd_data;
          end
        end else if (accept) begin
          mem_cmd_valid = 1'b1;
          if (victim_dirty) begin
            // push the old block out first
            mem_cmd    = '{op: OP_WRITE, addr: victim_addr, wdata: rd_data};
            next_state = ST_WRITEBACK;
          end else begin
            next_state = ST_FILL;
          end
        end
      end
      ST_WRITEBACK: begin
        if (mem_done) begin
          mem_cmd_valid = 1'b1;
          next_state    = ST_FILL;
        end
      end
      ST_FILL: begin
        if (mem_done) begin
          tag_fill  = 1'b1;
          data_fill = 1'b1;
          if (cur.op == OP_WRITE) begin
            data_write = 1'b1;
            mark_dirty = 1'b1;
          end else begin
            resp_next.rdata = mem_rdata;
          end
          if (resp_free) begin
            resp_load  = 1'b1;
            next_state = ST_IDLE;
          end else begin
            next_state = ST_RESPOND;
          end
        end
      end
      ST_RESPOND: begin
        // line is filled by now, so the array holds the answer
        if (resp_free) begin
          resp_load = 1'b1;
          if (cur.op == OP_READ) begin
            resp_next.rdata = rd_data;
          end
          next_state = ST_IDLE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state_q      <= ST_IDLE;
      resp_valid_q <= 1'b0;
    end else begin
      state_q <= next_state;
      if (resp_load) begin
        resp_valid_q <= 1'b1;
      end else if (proc_resp_ready) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (accept) begin
      saved_q <= proc_req;
    end
    if (resp_load) begin
      resp_q <= resp_next;
    end
  end

  assign proc_resp       = resp_q;
  assign proc_resp_valid = resp_valid_q;

  a_resp_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
    proc_resp_valid && !proc_resp_ready |=> proc_resp_valid && $stable(proc_resp))
    else $error("proc_resp changed while held");

  a_req_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    proc_req_valid |-> proc_req.addr[OFFSET_W-1:0] == '0)
    else $error("unaligned processor request address");

endmodule

// ==== verilog/axil_cache.sv ====
`timescale 1ns/1ns

module axil_cache (
  input  logic                  ACLK,
  input  logic                  ARESETn,
  input  cache_pkg::proc_req_t  proc_req,
  input  logic                  proc_req_valid,
  output logic                  proc_req_ready,
  output cache_pkg::proc_resp_t proc_resp,
  output logic                  proc_resp_valid,
  input  logic                  proc_resp_ready,
  output cache_pkg::mem_req_t   mem_req,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  input  logic                  mem_resp_valid,
  input  cache_pkg::data_t      mem_resp_rdata,
  output logic                  mem_resp_ready
);
  import cache_pkg::*;

  // lookup and update path
  addr_t    lookup_addr;
  addr_t    victim_addr;
  logic     hit;
  logic     victim_dirty;
  logic     tag_fill;
  logic     mark_dirty;
  logic     data_fill;
  logic     data_write;
  data_t    wdata;
  strb_t    wstrb;
  data_t    rd_data;

  // controller to memory port
  mem_req_t mem_cmd;
  logic     mem_cmd_valid;
  logic     mem_done;
  data_t    mem_rdata;

  cache_ctrl u_cache_ctrl (
    .ACLK            (ACLK),
    .ARESETn         (ARESETn),
    .proc_req        (proc_req),
    .proc_req_valid  (proc_req_valid),
    .proc_req_ready  (proc_req_ready),
    .proc_resp       (proc_resp),
    .proc_resp_valid (proc_resp_valid),
    .proc_resp_ready (proc_resp_ready),
    .lookup_addr     (lookup_addr),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .victim_addr     (victim_addr),
    .tag_fill        (tag_fill),
    .mark_dirty      (mark_dirty),
    .data_fill       (data_fill),
    .data_write      (data_write),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .rd_data         (rd_data),
    .mem_cmd         (mem_cmd),
    .mem_cmd_valid   (mem_cmd_valid),
    .mem_done        (mem_done),
    .mem_rdata       (mem_rdata)
  );

  cache_tags u_cache_tags (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .lookup_addr  (lookup_addr),
    .tag_fill     (tag_fill),
    .mark_dirty   (mark_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr)
  );

  cache_data u_cache_data (
    .ACLK      (ACLK),
    .index     (lookup_addr[OFFSET_W +: INDEX_W]),
    .fill      (data_fill),
    .write     (data_write),
    .fill_data (mem_rdata),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .rd_data   (rd_data)
  );

  mem_port u_mem_port (
    .ACLK           (ACLK),
    .ARESETn        (ARESETn),
    .cmd            (mem_cmd),
    .cmd_valid      (mem_cmd_valid),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata),
    .mem_resp_ready (mem_resp_ready),
    .done           (mem_done),
    .done_rdata     (mem_rdata)
  );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model #(
  parameter cache_pkg::data_t INIT_XOR = 32'h0,
  parameter int               SEED     = 1
) (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  cache_pkg::mem_req_t mem_req,
  input  logic                mem_req_valid,
  output logic                mem_req_ready,
  output logic                mem_resp_valid,
  output cache_pkg::data_t    mem_resp_rdata,
  input  logic                mem_resp_ready,
  output int                  read_count,
  output int                  write_count,
  output cache_pkg::mem_req_t last_req,
  output cache_pkg::mem_req_t prev_req
);
  import cache_pkg::*;

  // sparse storage, only written words are kept
  data_t words [addr_t];
  int    seed;

  function automatic int rand_delay();
    int r;
    r = $random(seed);
    return r & 3;
  endfunction

  function automatic data_t stored_word(addr_t addr);
    if (words.exists(addr)) begin
      return words[addr];
    end
    return addr ^ INIT_XOR;
  endfunction

  initial begin
    mem_req_t req;
    seed           = SEED;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    read_count     = 0;
    write_count    = 0;
    last_req       = '0;
    prev_req       = '0;
    forever begin
      @(negedge ACLK);
      if (ARESETn && mem_req_valid) begin
        repeat (rand_delay()) @(negedge ACLK);
        // payload is stable until the transfer
        req           = mem_req;
        mem_req_ready = 1'b1;
        @(negedge ACLK);
        mem_req_ready = 1'b0;
        prev_req      = last_req;
        last_req      = req;
        if (req.op == OP_WRITE) begin
          words[req.addr] = req.wdata;
          write_count++;
          mem_resp_rdata = '0;
        end else begin
          read_count++;
          mem_resp_rdata = stored_word(req.addr);
        end
        repeat (rand_delay()) @(negedge ACLK);
        while (!mem_resp_ready) begin
          @(negedge ACLK);
        end
        mem_resp_valid = 1'b1;
        @(negedge ACLK);
        mem_resp_valid = 1'b0;
      end
    end
  end

endmodule

// ==== sim/tb_axil_cache.sv ====
`timescale 1ns/1ns

module tb_axil_cache;
  import cache_pkg::*;

  localparam int    SEED           = 32'h0686759a;
  localparam data_t MEM_INIT_XOR   = 32'h5a5a_c3c3;
  localparam int    N_DIRECTED     = 9;
  localparam int    N_STALL        = 40;
  localparam int    N_MIX          = 200;
  localparam int    TIMEOUT_CYCLES = 40 * (N_DIRECTED + N_STALL + N_MIX);

  logic       ACLK;
  logic       ARESETn;
  proc_req_t  proc_req;
  logic       proc_req_valid;
  logic       proc_req_ready;
  proc_resp_t proc_resp;
  logic       proc_resp_valid;
  logic       proc_resp_ready;
  mem_req_t   mem_req;
  logic       mem_req_valid;
  logic       mem_req_ready;
  logic       mem_resp_valid;
  data_t      mem_resp_rdata;
  logic       mem_resp_ready;
  int         mem_reads;
  int         mem_writes;
  mem_req_t   mem_last;
  mem_req_t   mem_prev;

  // word each address should hold
  data_t      shadow [addr_t];
  proc_resp_t expected_q [$];
  int         stim_seed;
  int         stall_seed;
  logic       stall_en;
  int         cycles = 0;
  int         error_count;
  int         check_count;
  int         tests_run;
  int         tests_failed;

  initial ACLK = 1'b0;
  always #2 ACLK = ~ACLK;

  axil_cache u_axil_cache (
    .ACLK            (ACLK),
    .ARESETn         (ARESETn),
    .proc_req        (proc_req),
    .proc_req_valid  (proc_req_valid),
    .proc_req_ready  (proc_req_ready),
    .proc_resp       (proc_resp),
    .proc_resp_valid (proc_resp_valid),
    .proc_resp_ready (proc_resp_ready),
    .mem_req         (mem_req),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp_rdata  (mem_resp_rdata),
    .mem_resp_ready  (mem_resp_ready)
  );

  tb_mem_model #(
    .INIT_XOR (MEM_INIT_XOR),
    .SEED     (SEED + 2)
  ) u_mem_model (
    .ACLK           (ACLK),
    .ARESETn        (ARESETn),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata),
    .mem_resp_ready (mem_resp_ready),
    .read_count     (mem_reads),
    .write_count    (mem_writes),
    .last_req       (mem_last),
    .prev_req       (mem_prev)
  );

  function automatic data_t mem_init_word(addr_t addr);
    return addr ^ MEM_INIT_XOR;
  endfunction

  function automatic data_t shadow_word(addr_t addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return mem_init_word(addr);
  endfunction

  // expected response, the shadow also follows every write
  function automatic proc_resp_t ref_access(req_op_e op, addr_t addr, data_t wdata,
                                            strb_t wstrb);
    data_t word;
    word = shadow_word(addr);
    if (op == OP_READ) begin
      return '{op: OP_READ, rdata: word};
    end
    for (int i = 0; i < STRB_W; i++) begin
      if (wstrb[i]) begin
        word[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    shadow[addr] = word;
    return '{op: OP_WRITE, rdata: '0};
  endfunction

  task automatic check_value(string name, data_t expected, data_t actual);
    check_count++;
    assert (actual == expected) else begin
      error_count++;
      $display("FAILED %s expected %h got %h", name, expected, actual);
    end
  endtask

  // starts and ends on a falling edge
  task automatic send_request(req_op_e op, addr_t addr, data_t wdata, strb_t wstrb);
    proc_req       = '{op: op, addr: addr, wdata: wdata, wstrb: wstrb};
    proc_req_valid = 1'b1;
    #1;
    while (!proc_req_ready) begin
      @(negedge ACLK);
      #1;
    end
    expected_q.push_back(ref_access(op, addr, wdata, wstrb));
    @(negedge ACLK);
    proc_req_valid = 1'b0;
  endtask

  // 4 sets times 4 tags keeps conflicts frequent
  task automatic send_random(int count);
    int      r;
    addr_t   addr;
    data_t   wdata;
    req_op_e op;
    for (int n = 0; n < count; n++) begin
      r     = $random(stim_seed);
      wdata = $random(stim_seed);
      addr  = '0;
      addr[OFFSET_W +: 2]         = r[1:0];
      addr[OFFSET_W+INDEX_W +: 2] = r[3:2];
      op = r[4] ? OP_WRITE : OP_READ;
      send_request(op, addr, wdata, r[8:5]);
    end
  endtask

  task automatic drain();
    while (expected_q.size() != 0) begin
      @(negedge ACLK);
    end
  endtask

  task automatic report_test(string name, int errors_before);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
  endtask

  // drives ready, compares transfers and watches held responses
  initial begin
    proc_resp_t held;
    proc_resp_t exp;
    logic       held_v;
    int         r;
    held_v          = 1'b0;
    proc_resp_ready = 1'b1;
    forever begin
      @(negedge ACLK);
      r = $random(stall_seed);
      proc_resp_ready = stall_en ? (r[1:0] == 2'b00) : 1'b1;
      #1;
      if (held_v) begin
        check_count++;
        assert (proc_resp_valid && proc_resp == held) else begin
          error_count++;
          $display("FAILED proc_resp held expected %h got %h", held, proc_resp);
        end
      end
      held_v = 1'b0;
      if (ARESETn && proc_resp_valid && proc_resp_ready) begin
        check_count++;
        assert (expected_q.size() != 0) else begin
          error_count++;
          $display("a response arrived with no request outstanding");
        end
        if (expected_q.size() != 0) begin
          exp = expected_q.pop_front();
          check_value("proc_resp.op", 32'(exp.op), 32'(proc_resp.op));
          check_value("proc_resp.rdata", exp.rdata, proc_resp.rdata);
        end
      end else if (ARESETn && proc_resp_valid) begin
        held   = proc_resp;
        held_v = 1'b1;
      end
    end
  end

  always @(posedge ACLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with requests still pending", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int    errs;
    int    reads_before;
    int    writes_before;
    addr_t a;
    addr_t b;
    stim_seed      = SEED;
    stall_seed     = SEED + 1;
    stall_en       = 1'b0;
    error_count    = 0;
    check_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    proc_req       = '0;
    proc_req_valid = 1'b0;
    ARESETn        = 1'b0;
    repeat (16) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;
    @(negedge ACLK);

    // idle handshake levels out of reset
    errs = error_count;
    check_value("proc_resp_valid", '0, 32'(proc_resp_valid));
    check_value("mem_req_valid", '0, 32'(mem_req_valid));
    check_value("mem_resp_ready", '0, 32'(mem_resp_ready));
    check_value("proc_req_ready", 32'h1, 32'(proc_req_ready));
    report_test("reset state", errs);

    errs         = error_count;
    a            = 32'h0000_1040;
    reads_before = mem_reads;
    send_request(OP_READ, a, '0, '0);
    drain();
    check_value("mem_reads", reads_before + 1, mem_reads);
    report_test("read miss", errs);

    errs         = error_count;
    reads_before = mem_reads;
    send_request(OP_READ, a, '0, '0);
    drain();
    check_value("mem_reads", reads_before, mem_reads);
    report_test("read hit", errs);

    // index 1 is allocated by the first write and hit by the second
    errs = error_count;
    a    = 32'h0000_2084;
    send_request(OP_WRITE, a, 32'h1122_3344, 4'b0101);
    send_request(OP_READ, a, '0, '0);
    send_request(OP_WRITE, a, 32'haabb_ccdd, 4'b1010);
    send_request(OP_READ, a, '0, '0);
    drain();
    report_test("strobed write then read", errs);

    // b shares index 2 with a under another tag
    errs = error_count;
    a    = 32'h0000_3108;
    b    = a + 32'h0000_0040;
    send_request(OP_WRITE, a, 32'hcafe_f00d, 4'b0011);
    drain();
    writes_before = mem_writes;
    send_request(OP_READ, b, '0, '0);
    drain();
    check_value("mem_writes", writes_before + 1, mem_writes);
    check_value("mem_req.op", 32'(OP_WRITE), 32'(mem_prev.op));
    check_value("mem_req.addr", a, mem_prev.addr);
    check_value("mem_req.wdata", shadow_word(a), mem_prev.wdata);
    check_value("mem_req.op", 32'(OP_READ), 32'(mem_last.op));
    check_value("mem_req.addr", b, mem_last.addr);
    reads_before = mem_reads;
    send_request(OP_READ, a, '0, '0);
    drain();
    check_value("mem_reads", reads_before + 1, mem_reads);
    report_test("dirty eviction", errs);

    errs     = error_count;
    stall_en = 1'b1;
    send_random(N_STALL);
    drain();
    stall_en = 1'b0;
    report_test("response back-pressure", errs);

    errs = error_count;
    send_random(N_MIX);
    drain();
    report_test("random mix", errs);

    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d cycles",
             tests_run, tests_failed, check_count, error_count, cycles);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/cache_pkg.sv
verilog/cache_tags.sv
verilog/cache_data.sv
verilog/mem_port.sv
verilog/cache_ctrl.sv
verilog/axil_cache.sv
sim/tb_mem_model.sv
sim/tb_axil_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axil_cache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
